// File: Makefile
SIM      := verilator
TOP      := cacheSubsystemTb
FILELIST := cacheSubsystem.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD)
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Test completed successfully

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: cacheSubsystem.f
hw/cacheGeomPkg.sv
hw/cacheMsgPkg.sv
hw/cacheIfs.sv
hw/cacheLine.sv
hw/backingStore.sv
hw/reqDecode.sv
hw/lineExecute.sv
hw/rspResult.sv
hw/cacheSubsystem.sv
verification/cacheSubsystemTb.sv

// File: hw/backingStore.sv
`timescale 1ns/10ps
`default_nettype none

module backingStore
  import cacheGeomPkg::*;
(
  input  wire logic                         clk,
  input  wire logic [$clog2(MEM_WORDS)-1:0] memAddr,
  input  wire logic                         memWrite,
  input  wire logic [31:0]                  memWdata,
  output logic [31:0]                       memRdata
);

  logic [31:0] mem [MEM_WORDS];

  // each word starts out holding its own word index.
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (memWrite) mem[memAddr] <= memWdata;
    memRdata <= mem[memAddr];   // one cycle of read latency.
  end

endmodule

`default_nettype wire

// File: hw/cacheGeomPkg.sv
`default_nettype none

package cacheGeomPkg;

  localparam int ADDR_WIDTH     = 12;
  localparam int OFFSET_WIDTH   = 4;
  localparam int INDEX_WIDTH    = 3;
  localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int WORDS_PER_LINE = 4;
  localparam int MEM_WORDS      = 1024;

  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;   // byte offset, upper two bits pick the word.
  } cacheAddr_t;

  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    cacheAddr_t            fields;
  } cacheAddr_u;

  typedef logic [$clog2(WORDS_PER_LINE)-1:0] wordIdx_t;

endpackage

`default_nettype wire

// File: hw/cacheIfs.sv
`timescale 1ns/10ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request path into the line FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface cacheReqIf
  import cacheMsgPkg::*;
();

  logic      valid;
  cacheReq_t req;
  logic      ready;   // high only while the FSM is idle.

  modport issuer (
    output valid,
    output req,
    input  ready
  );

  modport taker (
    input  valid,
    input  req,
    output ready
  );

endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// completed access, no stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface cacheRspIf;

  logic        done;    // one-cycle pulse per finished access.
  logic        write;
  logic [31:0] data;
  logic        hit;

  modport producer (
    output done,
    output write,
    output data,
    output hit
  );

  modport consumer (
    input done,
    input write,
    input data,
    input hit
  );

endinterface

`default_nettype wire

// File: hw/cacheLine.sv
`timescale 1ns/10ps
`default_nettype none

module cacheLine
  import cacheGeomPkg::*;
(
  input  wire  logic                 clk,
  input  wire  logic                 rst_n,

  input  wire  cacheAddr_u           lookupAddr,
  output logic [31:0]                lookupData,
  output logic                       lineValid,
  output logic                       lineDirty,
  output logic                       lineHit,
  output logic [TAG_WIDTH-1:0]       lineTag,

  input  wire  logic                 write,
  input  wire  wordIdx_t             wrWord,
  input  wire  logic [TAG_WIDTH-1:0] wrTag,
  input  wire  logic                 wrValid,
  input  wire  logic                 wrDirty,
  input  wire  logic [31:0]          wrData,
  output logic [31:0]                victimData
);

  logic [31:0]          words [WORDS_PER_LINE];
  logic                 valid;
  logic                 dirty;
  logic [TAG_WIDTH-1:0] tag;

  assign lookupData = words[lookupAddr.fields.offset[OFFSET_WIDTH-1:2]];
  assign lineValid  = valid;
  assign lineDirty  = dirty;
  assign lineTag    = tag;
  assign lineHit    = valid && (tag == lookupAddr.fields.tag);
  assign victimData = words[wrWord];   // also used for the writeback walk.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
      dirty <= 1'b0;
    end else if (write) begin
      valid <= wrValid;
      dirty <= wrDirty;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      tag           <= wrTag;
      words[wrWord] <= wrData;
    end
  end

endmodule

`default_nettype wire

// File: hw/cacheMsgPkg.sv
`default_nettype none

package cacheMsgPkg;

  import cacheGeomPkg::*;

  typedef struct packed {
    logic        write;
    cacheAddr_u  addr;
    logic [31:0] wdata;
  } cacheReq_t;

  typedef struct packed {
    logic [31:0] data;
    logic        hit;
  } cacheRsp_t;

endpackage

`default_nettype wire

// File: hw/cacheSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module cacheSubsystem
  import cacheGeomPkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  reqValid,
  input  wire logic                  reqWrite,
  input  wire logic [ADDR_WIDTH-1:0] reqAddr,
  input  wire logic [31:0]           reqWdata,
  output logic                       reqCredit,
  output logic                       rspValid,
  output logic [31:0]                rspData,
  output logic                       rspHit
);

  cacheReqIf reqLink ();
  cacheRspIf rspLink ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request queue, line FSM, reply
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  reqDecode #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uDecode (
    .clk, .rst_n,
    .reqValid, .reqWrite, .reqAddr, .reqWdata,
    .reqCredit,
    .issue (reqLink.issuer)
  );

  lineExecute uExecute (
    .clk, .rst_n,
    .take (reqLink.taker),
    .done (rspLink.producer)
  );

  rspResult uResult (
    .clk, .rst_n,
    .done (rspLink.consumer),
    .rspValid, .rspData, .rspHit
  );

endmodule

`default_nettype wire

// File: hw/lineExecute.sv
`timescale 1ns/10ps
`default_nettype none

module lineExecute
  import cacheGeomPkg::*, cacheMsgPkg::*;
(
  input wire logic     clk,
  input wire logic     rst_n,
  cacheReqIf.taker     take,
  cacheRspIf.producer  done
);

  localparam int NUM_LINES = 2 ** INDEX_WIDTH;

  typedef enum logic [1:0] {stIdle, stLookup, stWriteback, stRefill} state_t;

  state_t                 state;
  cacheReq_t              curReq;
  wordIdx_t               cnt;
  wordIdx_t               nextCnt;
  logic [INDEX_WIDTH-1:0] idx;
  logic [TAG_WIDTH-1:0]   reqTag;
  wordIdx_t               reqWord;

  logic [31:0]            lookupDataArr [NUM_LINES];
  logic [31:0]            victimDataArr [NUM_LINES];
  logic [TAG_WIDTH-1:0]   tagArr [NUM_LINES];
  logic [NUM_LINES-1:0]   validArr, dirtyArr, hitArr;

  logic                   lineWrite, wrDirty, memWrite;
  wordIdx_t               wrWord;
  logic [31:0]            wrData, memRdata;
  logic [TAG_WIDTH+INDEX_WIDTH+1:0] memAddr;
  logic                   selHit, selVictim;

  assign idx       = curReq.addr.fields.index;
  assign reqTag    = curReq.addr.fields.tag;
  assign reqWord   = curReq.addr.fields.offset[OFFSET_WIDTH-1:2];
  assign nextCnt   = cnt + 1'b1;
  assign selHit    = hitArr[idx];
  assign selVictim = validArr[idx] && dirtyArr[idx];

  for (genvar i = 0; i < NUM_LINES; i++) begin : gLine
    cacheLine uLine (
      .clk, .rst_n,
      .lookupAddr (curReq.addr),      .lookupData (lookupDataArr[i]),
      .lineValid  (validArr[i]),      .lineDirty  (dirtyArr[i]),
      .lineHit    (hitArr[i]),        .lineTag    (tagArr[i]),
      .write      (lineWrite && (idx == INDEX_WIDTH'(i))),
      .wrWord, .wrTag (reqTag), .wrValid (1'b1), .wrDirty, .wrData,
      .victimData (victimDataArr[i])
    );
  end

  backingStore uStore (
    .clk, .memAddr, .memWrite, .memWdata (victimDataArr[idx]), .memRdata
  );

  assign take.ready = (state == stIdle);
  assign done.write = curReq.write;
  assign done.hit   = (state == stLookup);
  assign done.data  = (state == stRefill && reqWord == 2'd3) ? memRdata : lookupDataArr[idx];

  always_comb begin
    lineWrite = 1'b0;
    wrWord    = cnt;
    wrDirty   = 1'b1;
    wrData    = curReq.wdata;
    memWrite  = 1'b0;
    memAddr   = {reqTag, idx, 2'd0};   // default is the first refill read.
    done.done = 1'b0;
    case (state)
      stLookup: begin
        if (selHit) begin
          done.done = 1'b1;
          lineWrite = curReq.write;
          wrWord    = reqWord;
        end else begin
          wrWord = '0;
          if (selVictim) begin
            memWrite = 1'b1;   // victim word 0 leaves right away.
            memAddr  = {tagArr[idx], idx, 2'd0};
          end
        end
      end
      stWriteback: begin
        if (cnt != '0) begin
          memWrite = 1'b1;
          memAddr  = {tagArr[idx], idx, cnt};
        end
      end
      stRefill: begin
        lineWrite = 1'b1;
        wrDirty   = curReq.write;
        wrData    = (curReq.write && cnt == reqWord) ? curReq.wdata : memRdata;
        memAddr   = {reqTag, idx, nextCnt};
        done.done = (cnt == 2'd3);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
      cnt   <= '0;
    end else begin
      case (state)
        stIdle:   if (take.valid) state <= stLookup;
        stLookup: begin
          if (selHit) state <= stIdle;
          else if (selVictim) begin
            state <= stWriteback;
            cnt   <= 2'd1;
          end else begin
            state <= stRefill;
            cnt   <= '0;
          end
        end
        stWriteback: begin
          if (cnt == '0) state <= stRefill;
          else cnt <= nextCnt;   // wraps to 0 after word 3.
        end
        default: begin
          cnt <= nextCnt;
          if (cnt == 2'd3) state <= stIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take.valid && take.ready) curReq <= take.req;
  end

  doneLeavesToIdle: assert property (@(posedge clk) disable iff (!rst_n)
    done.done |-> state != stIdle ##1 state == stIdle)
    else $error("done pulse out of sequence");
  acceptOnlyIdle: assert property (@(posedge clk) disable iff (!rst_n)
    (take.valid && take.ready) |=> state == stLookup && !take.ready)
    else $error("request accepted while the FSM was busy");

endmodule

`default_nettype wire

// File: hw/reqDecode.sv
`timescale 1ns/10ps
`default_nettype none

module reqDecode
  import cacheGeomPkg::*, cacheMsgPkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  reqValid,
  input  wire logic                  reqWrite,
  input  wire logic [ADDR_WIDTH-1:0] reqAddr,
  input  wire logic [31:0]           reqWdata,
  output logic                       reqCredit,
  cacheReqIf.issuer                  issue
);

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  cacheReq_t            fifo [FIFO_DEPTH];
  cacheReq_t            pushEntry;
  logic [PTR_WIDTH:0]   wrPtr;
  logic [PTR_WIDTH:0]   rdPtr;
  logic                 empty;
  logic                 full;
  logic                 pop;

  assign pushEntry.write    = reqWrite;
  assign pushEntry.addr.raw = reqAddr;
  assign pushEntry.wdata    = reqWdata;

  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[PTR_WIDTH] != rdPtr[PTR_WIDTH]) &&
                 (wrPtr[PTR_WIDTH-1:0] == rdPtr[PTR_WIDTH-1:0]);

  assign issue.valid = !empty;
  assign issue.req   = fifo[rdPtr[PTR_WIDTH-1:0]];
  assign pop         = issue.valid && issue.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      reqCredit <= 1'b0;
    end else begin
      if (reqValid) wrPtr <= wrPtr + 1'b1;
      if (pop) rdPtr <= rdPtr + 1'b1;
      reqCredit <= pop;   // credit returns one cycle after the pop.
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid) fifo[wrPtr[PTR_WIDTH-1:0]] <= pushEntry;
  end

  // the requester spent a credit it did not hold.
  noPushWhenFull: assert property (@(posedge clk) disable iff (!rst_n) reqValid |-> !full)
    else $error("request pushed into a full FIFO, credit violation");

endmodule

`default_nettype wire

// File: hw/rspResult.sv
`timescale 1ns/10ps
`default_nettype none

module rspResult
  import cacheMsgPkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_n,
  cacheRspIf.consumer done,
  output logic        rspValid,
  output logic [31:0] rspData,
  output logic        rspHit
);

  cacheRsp_t rspReg;

  assign rspData = rspReg.data;
  assign rspHit  = rspReg.hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rspValid <= 1'b0;
    else rspValid <= done.done;
  end

  always_ff @(posedge clk) begin
    if (done.done) begin
      rspReg.data <= done.write ? '0 : done.data;   // writes answer with zero.
      rspReg.hit  <= done.hit;
    end
  end

  // one response per done pulse, never stretched.
  singleRsp: assert property (@(posedge clk) disable iff (!rst_n)
    rspValid |=> !rspValid)
    else $error("response held longer than one done pulse");

endmodule

`default_nettype wire

// File: verification/cacheSubsystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module cacheSubsystemTb
  import cacheGeomPkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 200;   // cycles allowed for any single wait.
  localparam int MAX_REQS   = 1024;
  localparam int NUM_LINES  = 2 ** INDEX_WIDTH;

  logic                  clk;
  logic                  rst_n;
  logic                  reqValid;
  logic                  reqWrite;
  logic [ADDR_WIDTH-1:0] reqAddr;
  logic [31:0]           reqWdata;
  logic                  reqCredit;
  logic                  rspValid;
  logic [31:0]           rspData;
  logic                  rspHit;
  logic                  quickHit;   // request must hit and the pipeline is empty.

  logic [31:0]           modelMem [MEM_WORDS];
  logic [TAG_WIDTH-1:0]  modelTag [NUM_LINES];
  logic                  modelValid [NUM_LINES];
  logic [31:0]           expData [MAX_REQS];
  logic                  expHit [MAX_REQS];
  int                    sentCount = 0;
  int                    rspCount = 0;
  int                    creditTotal = 0;

  cacheSubsystem #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk, .rst_n,
    .reqValid, .reqWrite, .reqAddr, .reqWdata,
    .reqCredit,
    .rspValid, .rspData, .rspHit
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // outputs change at the rising edge, so these see the value of the cycle just ended.
  always @(posedge clk) begin
    if (rst_n && rspValid) rspCount <= rspCount + 1;
    if (rst_n && reqCredit) creditTotal <= creditTotal + 1;
  end

  task automatic endInFailure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic int creditsHeld();
    return FIFO_DEPTH - sentCount + creditTotal;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  noStrayRsp: assert property (@(negedge clk) disable iff (!rst_n)
    rspValid |-> rspCount < sentCount)
    else endInFailure($sformatf("[ERROR] %0t: response with no request outstanding", $time));
  rspDataOk: assert property (@(negedge clk) disable iff (!rst_n)
    rspValid |-> rspData == expData[rspCount % MAX_REQS])
    else endInFailure($sformatf("[ERROR] %0t: response %0d data %h, expected %h",
                                $time, rspCount, rspData, expData[rspCount % MAX_REQS]));
  rspHitOk: assert property (@(negedge clk) disable iff (!rst_n)
    rspValid |-> rspHit == expHit[rspCount % MAX_REQS])
    else endInFailure($sformatf("[ERROR] %0t: response %0d hit %b, expected %b",
                                $time, rspCount, rspHit, expHit[rspCount % MAX_REQS]));
  hitLatency: assert property (@(posedge clk) disable iff (!rst_n)
    reqValid && quickHit |-> ##1 !rspValid ##1 !rspValid ##1 rspValid)
    else endInFailure($sformatf("[ERROR] %0t: hit response not 3 cycles after request", $time));

  // called at a falling edge, returns at the next one.
  task automatic sendReq(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                         input logic [31:0] data, input logic quick);
    int                     cycles;
    int                     wordAddr;
    logic [INDEX_WIDTH-1:0] idx;
    logic [TAG_WIDTH-1:0]   tag;
    cycles = 0;
    while (creditsHeld() == 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) endInFailure("timed out waiting for a request credit");
    end
    idx      = addr[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH];
    tag      = addr[ADDR_WIDTH-1:OFFSET_WIDTH+INDEX_WIDTH];
    wordAddr = int'(addr[ADDR_WIDTH-1:2]);
    expHit[sentCount % MAX_REQS]  = modelValid[idx] && (modelTag[idx] == tag);
    expData[sentCount % MAX_REQS] = wr ? 32'd0 : modelMem[wordAddr];
    if (wr) modelMem[wordAddr] = data;   // write-allocate, so the line is resident afterwards.
    modelValid[idx] = 1'b1;
    modelTag[idx]   = tag;
    sentCount++;
    reqValid = 1'b1;
    reqWrite = wr;
    reqAddr  = addr;
    reqWdata = data;
    quickHit = quick;
    @(negedge clk);
    reqValid = 1'b0;
    quickHit = 1'b0;
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (rspCount != sentCount) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) endInFailure("timed out waiting for outstanding responses");
    end
  endtask

  initial begin
    logic [ADDR_WIDTH-1:0] addr;
    int                    burst;
    void'($urandom(32'h31baf7d0));
    rst_n    = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr  = '0;
    reqWdata = '0;
    quickHit = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) modelMem[i] = 32'(i);
    for (int i = 0; i < NUM_LINES; i++) modelValid[i] = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed cases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sendReq(1'b0, 12'h040, 32'd0, 1'b0);   // cold misses on three lines.
    sendReq(1'b0, 12'h3f8, 32'd0, 1'b0);
    sendReq(1'b0, 12'h124, 32'd0, 1'b0);
    drain();
    sendReq(1'b0, 12'h044, 32'd0, 1'b1);
    drain();
    sendReq(1'b0, 12'h3fc, 32'd0, 1'b1);
    drain();
    sendReq(1'b1, 12'h048, 32'h5a5a_0048, 1'b1);
    drain();
    sendReq(1'b0, 12'h048, 32'd0, 1'b1);
    drain();
    sendReq(1'b0, 12'h0c8, 32'd0, 1'b0);   // same index, new tag evicts the dirty line.
    sendReq(1'b0, 12'h048, 32'd0, 1'b0);
    drain();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credit bursts and random mix
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (int b = 0; b < 20; b++) begin
      burst = $urandom_range(FIFO_DEPTH, 1);
      for (int k = 0; k < burst; k++) begin
        addr = ADDR_WIDTH'($urandom_range(MEM_WORDS - 1, 0) << 2);
        sendReq(1'($urandom), addr, $urandom, 1'b0);
      end
      repeat ($urandom_range(3, 0)) @(negedge clk);
    end
    drain();
    for (int n = 0; n < 300; n++) begin
      addr = 12'h200 | ADDR_WIDTH'($urandom_range(63, 0) << 2);   // two tags per index.
      sendReq(1'($urandom), addr, $urandom, 1'b0);
    end
    drain();

    if (creditTotal == sentCount) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      endInFailure($sformatf("[ERROR] %0t: %0d credits returned for %0d requests",
                             $time, creditTotal, sentCount));
    end
  end

endmodule

`default_nettype wire
